/* source/dsp_pkg.sv */
//##########################################################
// shared widths, counts and sequencer states for the dsp core
// referenced by scoped names from every rtl module
//##########################################################

package dsp_pkg;

	// processor cores feeding done and idle flags
	localparam int NPROC = 4;

	// readout channels, one accumulator each
	localparam int NCHAN = 4;

	// first NCHAN_G1 channels belong to group 1
	localparam int NCHAN_G1 = 2;

	// adc lanes
	localparam int NADC = 2;

	// signed adc or baseband sample
	typedef logic signed [15:0] sample_t;

	// signed accumulator result, also the buffer word
	typedef logic signed [31:0] acc_t;

	// accumulation buffer address, 256 entries
	typedef logic [7:0] accbuf_addr_t;

	// shot counter and nshot setting
	typedef logic [31:0] shot_cnt_t;

	// baseband source select
	// 0 own adc, 1 other adc, 2 and 3 give zero
	typedef logic [1:0] src_sel_t;

	// sequencer states, gray-ish walk through one shot
	typedef enum logic [3:0] {
		idle      = 4'b0000,
		start     = 4'b0001,
		proc_run  = 4'b0011,
		elem_busy = 4'b0010,
		more_shot = 4'b0110,
		shot_add  = 4'b0111,
		done      = 4'b0101
	} seq_state_t;

endpackage

/* source/shot_sequencer.sv */
//##########################################################
// multi-shot experiment sequencer
// releases cores from reset once per shot and counts shots
//##########################################################

`timescale 1ns/100ps

module shot_sequencer (
	input  logic                          dspif,
	input  logic                          rst_n,
	input  logic                          stb_start,
	input  dsp_pkg::shot_cnt_t            nshot,
	input  logic [dsp_pkg::NPROC-1:0]     proc_done,
	input  logic [dsp_pkg::NPROC-1:0]     elem_idle,
	output logic                          proc_reset,
	output dsp_pkg::shot_cnt_t            shot_cnt,
	output logic                          last_shot_done
);

	dsp_pkg::seq_state_t state;
	dsp_pkg::seq_state_t next_state;

	// nshot copy taken while idle
	dsp_pkg::shot_cnt_t nshot_r;

	// running shot index and its successor
	dsp_pkg::shot_cnt_t shot_idx;
	dsp_pkg::shot_cnt_t next_idx;

	// registered and of the per-core flags
	logic all_done_r;
	logic all_idle_r;

	// another shot is due after the current one
	logic more_shots;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			state <= dsp_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = dsp_pkg::idle;
		case (state)
			dsp_pkg::idle:      next_state = stb_start ? dsp_pkg::start : dsp_pkg::idle;
			dsp_pkg::start:     next_state = dsp_pkg::proc_run;
			// wait for every core to finish its program
			dsp_pkg::proc_run:  next_state = all_done_r ? dsp_pkg::elem_busy : dsp_pkg::proc_run;
			// then for every signal element to drain
			dsp_pkg::elem_busy: next_state = all_idle_r ? dsp_pkg::more_shot : dsp_pkg::elem_busy;
			dsp_pkg::more_shot: next_state = more_shots ? dsp_pkg::shot_add : dsp_pkg::done;
			dsp_pkg::shot_add:  next_state = dsp_pkg::start;
			dsp_pkg::done:      next_state = dsp_pkg::idle;
			default:            next_state = dsp_pkg::idle;
		endcase
	end

	// flags and lookahead count, settled long before more_shot
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			all_done_r <= 1'b0;
			all_idle_r <= 1'b0;
			next_idx   <= '0;
			more_shots <= 1'b0;
		end else begin
			all_done_r <= &proc_done;
			all_idle_r <= &elem_idle;
			next_idx   <= shot_idx + 1'b1;
			// nshot of zero means run until reset
			more_shots <= (next_idx != nshot_r) || (nshot_r == '0);
		end
	end

	// outputs decoded from the next state so they switch with it
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			proc_reset     <= 1'b1;
			last_shot_done <= 1'b0;
			shot_idx       <= '0;
			shot_cnt       <= '0;
			nshot_r        <= '0;
		end else begin
			last_shot_done <= (next_state == dsp_pkg::done);
			case (next_state)
				dsp_pkg::idle: begin
					proc_reset <= 1'b1;
					shot_idx   <= '0;
					nshot_r    <= nshot;
				end
				// cores run only in these two
				dsp_pkg::start, dsp_pkg::proc_run: begin
					proc_reset <= 1'b0;
				end
				dsp_pkg::shot_add: begin
					proc_reset <= 1'b1;
					// publish the index of the shot just finished
					shot_cnt   <= shot_idx;
					shot_idx   <= next_idx;
				end
				dsp_pkg::done: begin
					proc_reset <= 1'b1;
					shot_idx   <= '0;
				end
				default: begin
					proc_reset <= 1'b1;
				end
			endcase
		end
	end

	// cores stay in reset whenever no experiment runs
	a_idle_reset: assert property (@(posedge dspif) disable iff (!rst_n)
		(state == dsp_pkg::idle) |-> proc_reset)
		else $error("proc_reset low while sequencer idle");

	// end of experiment is a single-cycle pulse
	a_done_pulse: assert property (@(posedge dspif) disable iff (!rst_n)
		last_shot_done |=> !last_shot_done)
		else $error("last_shot_done held longer than one cycle");

endmodule

/* source/readout_front.sv */
//##########################################################
// readout front end, registers adc lanes and picks the
// baseband source per group, gates delayed to stay aligned
//##########################################################

`timescale 1ns/100ps

module readout_front (
	input  logic                          dspif,
	input  logic                          rst_n,
	input  dsp_pkg::sample_t              adc [dsp_pkg::NADC],
	input  dsp_pkg::src_sel_t             group1_sel,
	input  dsp_pkg::src_sel_t             group2_sel,
	input  logic [dsp_pkg::NCHAN-1:0]     gate,
	output dsp_pkg::sample_t              bb [dsp_pkg::NCHAN],
	output logic [dsp_pkg::NCHAN-1:0]     bb_gate
);

	// stage 1 lanes
	dsp_pkg::sample_t adc_r [dsp_pkg::NADC];
	// stage 2 per-group baseband
	dsp_pkg::sample_t bb_g1;
	dsp_pkg::sample_t bb_g2;
	logic [dsp_pkg::NCHAN-1:0] gate_d1;

	function automatic dsp_pkg::sample_t pick_src(
		input dsp_pkg::src_sel_t sel,
		input dsp_pkg::sample_t  own,
		input dsp_pkg::sample_t  other
	);
		case (sel)
			2'd0:    pick_src = own;
			2'd1:    pick_src = other;
			default: pick_src = '0;
		endcase
	endfunction

	always_ff @(posedge dspif) begin
		adc_r <= adc;
		// group 1 owns adc0, group 2 owns adc1
		bb_g1 <= pick_src(group1_sel, adc_r[0], adc_r[1]);
		bb_g2 <= pick_src(group2_sel, adc_r[1], adc_r[0]);
	end

	// two gate stages to match the sample path
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			gate_d1 <= '0;
			bb_gate <= '0;
		end else begin
			gate_d1 <= gate;
			bb_gate <= gate_d1;
		end
	end

	// fan each group baseband out to its channels
	for (genvar i = 0; i < dsp_pkg::NCHAN; i++) begin : g_fan
		if (i < dsp_pkg::NCHAN_G1) begin : g_grp1
			assign bb[i] = bb_g1;
		end else begin : g_grp2
			assign bb[i] = bb_g2;
		end
	end

endmodule

/* source/gated_accumulator.sv */
//##########################################################
// per-channel gated integrator
// sums baseband while the gate is high and strobes the sum out
//##########################################################

`timescale 1ns/100ps

module gated_accumulator (
	input  logic              dspif,
	input  logic              rst_n,
	input  dsp_pkg::sample_t  bb,
	input  logic              bb_gate,
	output logic              result_valid,
	output dsp_pkg::acc_t     result
);

	// gate one cycle back for edge detection
	logic gate_d;

	// running sum
	dsp_pkg::acc_t acc;

	// sign-extended sample
	dsp_pkg::acc_t bb_ext;

	// base is zero on the first gated sample
	dsp_pkg::acc_t acc_base;

	logic gate_fall;

	assign bb_ext    = dsp_pkg::acc_t'(bb);
	assign acc_base  = gate_d ? acc : '0;
	assign gate_fall = gate_d & ~bb_gate;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			gate_d       <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			gate_d       <= bb_gate;
			// strobe one cycle after the gate drops
			result_valid <= gate_fall;
		end
	end

	always_ff @(posedge dspif) begin
		if (bb_gate) begin
			acc <= acc_base + bb_ext;
		end
		// acc already holds the last gated sample here
		if (gate_fall) begin
			result <= acc;
		end
	end

	// one gate window gives exactly one strobe
	a_single_strobe: assert property (@(posedge dspif) disable iff (!rst_n)
		result_valid |=> !result_valid)
		else $error("result_valid on consecutive cycles");

endmodule

/* source/accbuf_writer.sv */
//##########################################################
// accumulation buffer write port for one channel
// address locks on the last entry, resetacc rewinds it
//##########################################################

`timescale 1ns/100ps

module accbuf_writer (
	input  logic                   dspif,
	input  logic                   rst_n,
	input  logic                   resetacc,
	input  logic                   result_valid,
	input  dsp_pkg::acc_t          result,
	output logic                   accbuf_we,
	output dsp_pkg::accbuf_addr_t  accbuf_addr,
	output dsp_pkg::acc_t          accbuf_data,
	output logic                   meas,
	output logic                   meas_valid
);

	// resetacc after one register stage
	logic resetacc_r;

	// address parked at the last entry
	logic locklast;

	assign locklast = &accbuf_addr;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			resetacc_r  <= 1'b0;
			accbuf_we   <= 1'b0;
			accbuf_addr <= '0;
			meas        <= 1'b0;
			meas_valid  <= 1'b0;
		end else begin
			resetacc_r <= resetacc;
			accbuf_we  <= result_valid;
			// step after each write, hold at 255
			if (resetacc_r) begin
				accbuf_addr <= '0;
			end else if (accbuf_we && !locklast) begin
				accbuf_addr <= accbuf_addr + 1'b1;
			end
			// threshold on the real axis sign
			meas       <= accbuf_data[31];
			meas_valid <= accbuf_we;
		end
	end

	always_ff @(posedge dspif) begin
		if (result_valid) begin
			accbuf_data <= result;
		end
	end

	// only resetacc may bring a full buffer back to 0
	a_no_wrap: assert property (@(posedge dspif) disable iff (!rst_n)
		(locklast && !resetacc_r) |=> locklast)
		else $error("accbuf address wrapped without resetacc");

endmodule

/* source/dsp_top.sv */
//##########################################################
// dsp core top, shot sequencer plus readout chain
// per channel: front end, gated accumulator, buffer writer
//##########################################################

`timescale 1ns/100ps

module dsp_top (
	input  logic                          dspif,
	input  logic                          rst_n,
	input  logic                          stb_start,
	input  dsp_pkg::shot_cnt_t            nshot,
	input  logic                          resetacc,
	input  logic [dsp_pkg::NPROC-1:0]     proc_done,
	input  logic [dsp_pkg::NPROC-1:0]     elem_idle,
	output logic                          proc_reset,
	output dsp_pkg::shot_cnt_t            shot_cnt,
	output logic                          last_shot_done,
	input  dsp_pkg::sample_t              adc [dsp_pkg::NADC],
	input  dsp_pkg::src_sel_t             group1_sel,
	input  dsp_pkg::src_sel_t             group2_sel,
	input  logic [dsp_pkg::NCHAN-1:0]     gate,
	output logic [dsp_pkg::NCHAN-1:0]     accbuf_we,
	output dsp_pkg::accbuf_addr_t         accbuf_addr [dsp_pkg::NCHAN],
	output dsp_pkg::acc_t                 accbuf_data [dsp_pkg::NCHAN],
	output logic [dsp_pkg::NCHAN-1:0]     meas,
	output logic [dsp_pkg::NCHAN-1:0]     meas_valid
);

	// aligned baseband and gates
	dsp_pkg::sample_t          bb [dsp_pkg::NCHAN];
	logic [dsp_pkg::NCHAN-1:0] bb_gate;

	// accumulator strobes and sums
	logic [dsp_pkg::NCHAN-1:0] result_valid;
	dsp_pkg::acc_t             result [dsp_pkg::NCHAN];

	shot_sequencer u_seq (
		.dspif          (dspif),
		.rst_n          (rst_n),
		.stb_start      (stb_start),
		.nshot          (nshot),
		.proc_done      (proc_done),
		.elem_idle      (elem_idle),
		.proc_reset     (proc_reset),
		.shot_cnt       (shot_cnt),
		.last_shot_done (last_shot_done)
	);

	readout_front u_front (
		.dspif      (dspif),
		.rst_n      (rst_n),
		.adc        (adc),
		.group1_sel (group1_sel),
		.group2_sel (group2_sel),
		.gate       (gate),
		.bb         (bb),
		.bb_gate    (bb_gate)
	);

	for (genvar i = 0; i < dsp_pkg::NCHAN; i++) begin : g_chan
		gated_accumulator u_acc (
			.dspif        (dspif),
			.rst_n        (rst_n),
			.bb           (bb[i]),
			.bb_gate      (bb_gate[i]),
			.result_valid (result_valid[i]),
			.result       (result[i])
		);

		accbuf_writer u_wr (
			.dspif        (dspif),
			.rst_n        (rst_n),
			.resetacc     (resetacc),
			.result_valid (result_valid[i]),
			.result       (result[i]),
			.accbuf_we    (accbuf_we[i]),
			.accbuf_addr  (accbuf_addr[i]),
			.accbuf_data  (accbuf_data[i]),
			.meas         (meas[i]),
			.meas_valid   (meas_valid[i])
		);
	end

endmodule

/* tb/tb_tasks.svh */
//##########################################################
// checks, random source, wait loops and directed tests
// included inside the testbench module body
//##########################################################

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	// upper bits, the low ones of an lcg cycle too fast
	function automatic dsp_pkg::sample_t rand_sample();
		logic [31:0] r;
		r = lcg_next();
		return r[31:16];
	endfunction

	// 1 to n
	function automatic int rand_range(input int n);
		logic [31:0] r;
		r = lcg_next();
		return 1 + int'(r[30:16]) % n;
	endfunction

	// baseband rule: 0 own lane, 1 other lane, else zero
	function automatic dsp_pkg::acc_t expected_sample(input dsp_pkg::src_sel_t sel,
		input dsp_pkg::sample_t own, input dsp_pkg::sample_t other);
		if (sel == 2'd0) return dsp_pkg::acc_t'(own);
		if (sel == 2'd1) return dsp_pkg::acc_t'(other);
		return '0;
	endfunction

	// drive point, 1 ns past the rising edge
	task automatic next_cycle();
		@(posedge dspif);
		#1;
	endtask

	task automatic check_after_reset();
		int ch;
		check_value("proc_reset", proc_reset, 1);
		check_value("last_shot_done", last_shot_done, 0);
		check_value("accbuf_we", accbuf_we, 0);
		check_value("meas_valid", meas_valid, 0);
		check_value("shot_cnt", shot_cnt, 0);
		for (ch = 0; ch < dsp_pkg::NCHAN; ch++)
			check_value($sformatf("accbuf_addr[%0d]", ch), accbuf_addr[ch], 0);
	endtask

	// core model plus monitor, ends on last_shot_done or after max_falls shot starts
	task automatic serve_shots(input int max_falls, output int falls, output int ends);
		int phase;
		int delay;
		int guard;
		logic prev_reset;
		falls = 0;
		ends = 0;
		phase = 0;
		delay = 0;
		guard = 0;
		prev_reset = proc_reset;
		while (ends == 0 && falls < max_falls && guard < 2000) begin
			next_cycle();
			stb_start = 1'b0;
			guard++;
			if (prev_reset && !proc_reset) begin
				falls++;
				// shot_cnt holds the index of the shot before this one
				if (falls >= 2)
					check_value("shot_cnt", shot_cnt, falls - 2);
				proc_done = '0;
				elem_idle = '0;
				phase = 1;
				delay = rand_range(8);
			end else if (phase != 0) begin
				delay--;
				if (delay == 0 && phase == 1) begin
					proc_done = '1;
					phase = 2;
					delay = rand_range(8);
				end else if (delay == 0) begin
					elem_idle = '1;
					phase = 0;
				end
			end
			if (last_shot_done)
				ends++;
			prev_reset = proc_reset;
		end
		if (ends == 0 && falls < max_falls) begin
			timeouts++;
			$display("timed out while the sequencer was running shots");
		end
	endtask

	// fixed window, sequencer must stay parked
	task automatic watch_quiet(input int n);
		int k;
		int falls;
		int pulses;
		logic prev_reset;
		falls = 0;
		pulses = 0;
		prev_reset = proc_reset;
		for (k = 0; k < n; k++) begin
			next_cycle();
			if (prev_reset && !proc_reset)
				falls++;
			if (last_shot_done)
				pulses++;
			prev_reset = proc_reset;
		end
		check_value("late proc_reset falls", falls, 0);
		check_value("late last_shot_done", pulses, 0);
		check_value("proc_reset", proc_reset, 1);
	endtask

	task automatic test_shots_finite();
		int falls;
		int ends;
		nshot = 32'd3;
		// nshot is only latched while idle
		next_cycle();
		stb_start = 1'b1;
		serve_shots(100, falls, ends);
		check_value("proc_reset falls", falls, 3);
		check_value("last_shot_done pulses", ends, 1);
		watch_quiet(40);
	endtask

	task automatic test_shots_endless();
		int falls;
		int ends;
		nshot = '0;
		next_cycle();
		stb_start = 1'b1;
		// sixth start means five shots completed
		serve_shots(6, falls, ends);
		check_value("proc_reset falls", falls, 6);
		check_value("last_shot_done pulses", ends, 0);
		rst_n = 1'b0;
		proc_done = '0;
		elem_idle = '0;
		repeat (3) next_cycle();
		check_after_reset();
		rst_n = 1'b1;
		exp_addr = 0;
		watch_quiet(10);
	endtask

	// one gate window on all channels, then the write and the meas bit
	task automatic run_gate(input int len, input dsp_pkg::src_sel_t s1,
		input dsp_pkg::src_sel_t s2);
		int k;
		int ch;
		int cycles;
		dsp_pkg::sample_t a0;
		dsp_pkg::sample_t a1;
		dsp_pkg::acc_t sum_g1;
		dsp_pkg::acc_t sum_g2;
		dsp_pkg::acc_t want;
		group1_sel = s1;
		group2_sel = s2;
		sum_g1 = '0;
		sum_g2 = '0;
		for (k = 0; k < len; k++) begin
			a0 = rand_sample();
			a1 = rand_sample();
			adc[0] = a0;
			adc[1] = a1;
			gate = '1;
			// group 1 owns adc0, group 2 owns adc1
			sum_g1 = sum_g1 + expected_sample(s1, a0, a1);
			sum_g2 = sum_g2 + expected_sample(s2, a1, a0);
			next_cycle();
		end
		gate = '0;
		// samples outside the window must not count
		adc[0] = rand_sample();
		adc[1] = rand_sample();
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
		end while (accbuf_we == '0 && cycles < 20);
		if (accbuf_we == '0) begin
			timeouts++;
			$display("timed out waiting for an accumulation buffer write");
		end
		check_value("write latency", cycles, 4);
		for (ch = 0; ch < dsp_pkg::NCHAN; ch++) begin
			want = (ch < dsp_pkg::NCHAN_G1) ? sum_g1 : sum_g2;
			check_value($sformatf("accbuf_we[%0d]", ch), accbuf_we[ch], 1);
			check_value($sformatf("accbuf_addr[%0d]", ch), accbuf_addr[ch], exp_addr);
			check_value($sformatf("accbuf_data[%0d]", ch), accbuf_data[ch], want);
		end
		next_cycle();
		for (ch = 0; ch < dsp_pkg::NCHAN; ch++) begin
			want = (ch < dsp_pkg::NCHAN_G1) ? sum_g1 : sum_g2;
			check_value($sformatf("meas_valid[%0d]", ch), meas_valid[ch], 1);
			check_value($sformatf("meas[%0d]", ch), meas[ch], want[31]);
		end
		// address parks on the last entry
		if (exp_addr < 255)
			exp_addr++;
	endtask

	task automatic test_readout_select();
		int n;
		for (n = 0; n < 3; n++)
			run_gate(rand_range(12), 2'd0, 2'd0);
		run_gate(rand_range(12), 2'd1, 2'd1);
		run_gate(rand_range(12), 2'd2, 2'd3);
	endtask

	task automatic test_address_lock();
		int n;
		int ch;
		for (n = 0; n < 260; n++)
			run_gate(1, 2'd0, 2'd0);
		for (ch = 0; ch < dsp_pkg::NCHAN; ch++)
			check_value($sformatf("accbuf_addr[%0d]", ch), accbuf_addr[ch], 255);
		resetacc = 1'b1;
		next_cycle();
		resetacc = 1'b0;
		repeat (2) next_cycle();
		for (ch = 0; ch < dsp_pkg::NCHAN; ch++)
			check_value($sformatf("accbuf_addr[%0d]", ch), accbuf_addr[ch], 0);
		exp_addr = 0;
		run_gate(3, 2'd0, 2'd0);
		check_value("accbuf_addr[0]", accbuf_addr[0], exp_addr);
	endtask

`endif

/* tb/tb_dsp.sv */
//##########################################################
// testbench for the dsp core, runs the directed tests in order
// test tasks and checks live in the included tb_tasks.svh
//##########################################################

`timescale 1ns/100ps

module tb_dsp;

	logic                        dspif;
	logic                        rst_n;
	logic                        stb_start;
	dsp_pkg::shot_cnt_t          nshot;
	logic                        resetacc;
	logic [dsp_pkg::NPROC-1:0]   proc_done;
	logic [dsp_pkg::NPROC-1:0]   elem_idle;
	logic                        proc_reset;
	dsp_pkg::shot_cnt_t          shot_cnt;
	logic                        last_shot_done;
	dsp_pkg::sample_t            adc [dsp_pkg::NADC];
	dsp_pkg::src_sel_t           group1_sel;
	dsp_pkg::src_sel_t           group2_sel;
	logic [dsp_pkg::NCHAN-1:0]   gate;
	logic [dsp_pkg::NCHAN-1:0]   accbuf_we;
	dsp_pkg::accbuf_addr_t       accbuf_addr [dsp_pkg::NCHAN];
	dsp_pkg::acc_t               accbuf_data [dsp_pkg::NCHAN];
	logic [dsp_pkg::NCHAN-1:0]   meas;
	logic [dsp_pkg::NCHAN-1:0]   meas_valid;

	// tallies for the closing line
	int checks;
	int errors;
	int timeouts;

	// lcg state
	logic [31:0] rng_state;

	// next buffer address, identical on every channel
	int exp_addr;

	`include "tb_tasks.svh"

	dsp_top DUT (.*);

	initial begin
		dspif = 1'b0;
		forever #5 dspif = ~dspif;
	end

	initial begin
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		rng_state  = 32'd88607;
		exp_addr   = 0;
		rst_n      = 1'b0;
		stb_start  = 1'b0;
		nshot      = '0;
		resetacc   = 1'b0;
		proc_done  = '0;
		elem_idle  = '0;
		adc[0]     = '0;
		adc[1]     = '0;
		group1_sel = '0;
		group2_sel = '0;
		gate       = '0;
		// 10 cycles in reset
		repeat (10) @(posedge dspif);
		#1;
		rst_n = 1'b1;
		check_after_reset();
		test_shots_finite();
		test_shots_endless();
		test_readout_select();
		test_address_lock();
		$display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+tb
source/dsp_pkg.sv
source/shot_sequencer.sv
source/readout_front.sv
source/gated_accumulator.sv
source/accbuf_writer.sv
source/dsp_top.sv
tb/tb_dsp.sv

/* run_sim.sh */
#!/bin/sh
# build the dsp core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp -f sources.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_dsp)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
